// File: source/riscv_pkg.sv
package riscv_pkg;

    // data and address words.
    typedef logic [31:0] word_t;

    // register index into the 32-entry file.
    typedef logic [4:0] reg_addr_t;

    // alu status, msb first: negative, zero, carry, overflow.
    typedef logic [3:0] alu_flags_t;

    // bit positions inside alu_flags_t.
    localparam int flag_neg = 3;
    localparam int flag_zero = 2;
    localparam int flag_carry = 1;
    localparam int flag_ovf = 0;

    // immediate layout selected by the decoder.
    typedef enum logic [2:0] {
        imm_itype,
        imm_stype,
        imm_btype,
        imm_jtype,
        imm_utype,
        // shamt field, zero-extended.
        imm_itype2
    } imm_src_e;

    // alu operations.
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_e;

    // alu operand sources.
    typedef enum logic [1:0] {
        src_reg_1,
        src_reg_2,
        src_ext_imm,
        src_pc
    } alu_src_e;

    // register write-back sources.
    typedef enum logic [1:0] {
        res_alu_out,
        res_pc_plus_4,
        res_ext_imm,
        res_mem
    } res_src_e;

    // next pc sources.
    typedef enum logic [1:0] {
        pc_plus_4,
        pc_plus_off,
        pc_reg_plus_off
    } pc_src_e;

    // everything the decoder hands to the datapath and memory port.
    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
        alu_src_e alu_src_a;
        alu_src_e alu_src_b;
        res_src_e result_src;
        pc_src_e  pc_src;
    } ctrl_t;

endpackage

// File: source/extend.sv
module extend (
    input  riscv_pkg::word_t    instr,
    input  riscv_pkg::imm_src_e imm_src,
    output riscv_pkg::word_t    ext_imm
);

    // candidate immediates, one per format.
    riscv_pkg::word_t imm_i;
    riscv_pkg::word_t imm_s;
    riscv_pkg::word_t imm_b;
    riscv_pkg::word_t imm_j;
    riscv_pkg::word_t imm_u;
    riscv_pkg::word_t imm_sh;

    // sign always comes from bit 31.
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // branch and jump offsets are in halfwords, lsb is implied zero.
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    // upper 20 bits, low 12 cleared.
    assign imm_u = {instr[31:12], 12'h000};
    // shift amount only.
    assign imm_sh = {27'd0, instr[24:20]};

    always_comb begin
        case (imm_src)
            riscv_pkg::imm_itype:  ext_imm = imm_i;
            riscv_pkg::imm_stype:  ext_imm = imm_s;
            riscv_pkg::imm_btype:  ext_imm = imm_b;
            riscv_pkg::imm_jtype:  ext_imm = imm_j;
            riscv_pkg::imm_utype:  ext_imm = imm_u;
            riscv_pkg::imm_itype2: ext_imm = imm_sh;
            default:               ext_imm = '0;
        endcase
    end

endmodule

// File: source/regfile.sv
module regfile (
    input  logic                 clk,
    input  riscv_pkg::reg_addr_t addr1,
    input  riscv_pkg::reg_addr_t addr2,
    input  riscv_pkg::reg_addr_t addr3,
    input  riscv_pkg::word_t     wd3,
    input  logic                 we,
    output riscv_pkg::word_t     rd1,
    output riscv_pkg::word_t     rd2
);

    // storage, entry 0 is never written.
    riscv_pkg::word_t regs [32];

    // write port on the rising edge.
    always_ff @(posedge clk) begin
        if (we && addr3 != 5'd0) begin
            regs[addr3] <= wd3;
        end
    end

    // x0 reads as zero regardless of contents.
    assign rd1 = (addr1 == 5'd0) ? '0 : regs[addr1];
    assign rd2 = (addr2 == 5'd0) ? '0 : regs[addr2];

endmodule

// File: source/alu.sv
module alu (
    input  riscv_pkg::word_t      a,
    input  riscv_pkg::word_t      b,
    input  riscv_pkg::alu_op_e    alu_ctrl,
    output riscv_pkg::word_t      result,
    output riscv_pkg::alu_flags_t flags
);

    logic             is_sub;
    riscv_pkg::word_t b_eff;
    logic [32:0]      sum;
    logic             carry;
    logic             ovf;

    // one adder serves add and sub.
    assign is_sub = (alu_ctrl == riscv_pkg::alu_sub);
    assign b_eff = is_sub ? ~b : b;
    assign sum = {1'b0, a} + {1'b0, b_eff} + {32'd0, is_sub};

    // operand signs agree and result sign differs.
    assign ovf = (a[31] == b_eff[31]) && (sum[31] != a[31]);
    assign carry = sum[32];

    always_comb begin
        case (alu_ctrl)
            riscv_pkg::alu_add: result = sum[31:0];
            riscv_pkg::alu_sub: result = sum[31:0];
            riscv_pkg::alu_and: result = a & b;
            riscv_pkg::alu_or:  result = a | b;
            riscv_pkg::alu_xor: result = a ^ b;
            riscv_pkg::alu_slt: result = {31'd0, $signed(a) < $signed(b)};
            // shift by low five bits of b.
            riscv_pkg::alu_sll: result = a << b[4:0];
            riscv_pkg::alu_srl: result = a >> b[4:0];
            default:            result = '0;
        endcase
    end

    // n and z from the result.
    assign flags[riscv_pkg::flag_neg] = result[31];
    assign flags[riscv_pkg::flag_zero] = (result == '0);
    // c and v only mean something for add and sub.
    assign flags[riscv_pkg::flag_carry] = (alu_ctrl inside {riscv_pkg::alu_add,
        riscv_pkg::alu_sub}) ? carry : 1'b0;
    assign flags[riscv_pkg::flag_ovf] = (alu_ctrl inside {riscv_pkg::alu_add,
        riscv_pkg::alu_sub}) ? ovf : 1'b0;

endmodule

// File: source/datapath.sv
module datapath #(
    parameter riscv_pkg::word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  riscv_pkg::word_t      instr,
    input  riscv_pkg::word_t      read_data,
    input  riscv_pkg::ctrl_t      ctrl,
    output riscv_pkg::word_t      pc,
    output riscv_pkg::word_t      alu_out,
    output riscv_pkg::alu_flags_t alu_flags,
    output riscv_pkg::word_t      write_data
);

    riscv_pkg::word_t ext_imm;
    riscv_pkg::word_t reg_rd1;
    riscv_pkg::word_t reg_rd2;
    riscv_pkg::word_t reg_wr_data;
    riscv_pkg::word_t alu_op_a;
    riscv_pkg::word_t alu_op_b;
    riscv_pkg::word_t pc_inc;
    riscv_pkg::word_t pc_branch;
    riscv_pkg::word_t pc_jump;
    riscv_pkg::word_t pc_next;

    // operand mux, shared by both alu inputs.
    function automatic riscv_pkg::word_t pick_operand(
        input riscv_pkg::alu_src_e src,
        input riscv_pkg::word_t    rd1,
        input riscv_pkg::word_t    rd2,
        input riscv_pkg::word_t    imm,
        input riscv_pkg::word_t    pc_now
    );
        case (src)
            riscv_pkg::src_reg_1:   return rd1;
            riscv_pkg::src_reg_2:   return rd2;
            riscv_pkg::src_ext_imm: return imm;
            default:                return pc_now;
        endcase
    endfunction

    // next pc candidates.
    assign pc_inc = pc + 32'd4;
    assign pc_branch = pc + ext_imm;
    // jalr target with bit 0 dropped.
    assign pc_jump = (reg_rd1 + ext_imm) & ~32'd1;

    always_comb begin
        case (ctrl.pc_src)
            riscv_pkg::pc_plus_off:     pc_next = pc_branch;
            riscv_pkg::pc_reg_plus_off: pc_next = pc_jump;
            default:                    pc_next = pc_inc;
        endcase
    end

    // pc register, one instruction per edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // write-back select.
    always_comb begin
        case (ctrl.result_src)
            riscv_pkg::res_pc_plus_4: reg_wr_data = pc_inc;
            riscv_pkg::res_ext_imm:   reg_wr_data = ext_imm;
            riscv_pkg::res_mem:       reg_wr_data = read_data;
            default:                  reg_wr_data = alu_out;
        endcase
    end

    // rs1, rs2, rd from the fixed fields.
    regfile regfile_inst (
        .clk   (clk),
        .addr1 (instr[19:15]),
        .addr2 (instr[24:20]),
        .addr3 (instr[11:7]),
        .wd3   (reg_wr_data),
        .we    (ctrl.reg_we),
        .rd1   (reg_rd1),
        .rd2   (reg_rd2)
    );

    extend extend_inst (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .ext_imm (ext_imm)
    );

    assign alu_op_a = pick_operand(ctrl.alu_src_a, reg_rd1, reg_rd2, ext_imm, pc);
    assign alu_op_b = pick_operand(ctrl.alu_src_b, reg_rd1, reg_rd2, ext_imm, pc);

    alu alu_inst (
        .a        (alu_op_a),
        .b        (alu_op_b),
        .alu_ctrl (ctrl.alu_ctrl),
        .result   (alu_out),
        .flags    (alu_flags)
    );

    // store data is always rs2.
    assign write_data = reg_rd2;

    // jumps and branches never misalign the pc.
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    ) else $error("pc not word aligned");

endmodule

// File: source/control_unit.sv
module control_unit (
    input  logic                  rst_n,
    input  riscv_pkg::word_t      instr,
    input  riscv_pkg::alu_flags_t alu_flags,
    output riscv_pkg::ctrl_t      ctrl
);

    // major opcodes.
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7b5;
    logic       n_ne_v;
    logic       taken;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign f7b5 = instr[30];

    // signed less-than from the subtraction.
    assign n_ne_v = alu_flags[riscv_pkg::flag_neg] ^ alu_flags[riscv_pkg::flag_ovf];

    // branch condition by funct3.
    always_comb begin
        case (funct3)
            3'b000:  taken = alu_flags[riscv_pkg::flag_zero];
            3'b001:  taken = !alu_flags[riscv_pkg::flag_zero];
            3'b100:  taken = n_ne_v;
            3'b101:  taken = !n_ne_v;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        // defaults: no writes, rs1 + rs2, fall through.
        ctrl = '{reg_we: 1'b0, mem_we: 1'b0, imm_src: riscv_pkg::imm_itype,
                 alu_ctrl: riscv_pkg::alu_add, alu_src_a: riscv_pkg::src_reg_1,
                 alu_src_b: riscv_pkg::src_reg_2, result_src: riscv_pkg::res_alu_out,
                 pc_src: riscv_pkg::pc_plus_4};
        case (opcode)
            op_lui: begin
                ctrl.reg_we = 1'b1;
                ctrl.imm_src = riscv_pkg::imm_utype;
                ctrl.result_src = riscv_pkg::res_ext_imm;
            end
            op_auipc: begin
                ctrl.reg_we = 1'b1;
                ctrl.imm_src = riscv_pkg::imm_utype;
                ctrl.alu_src_a = riscv_pkg::src_pc;
                ctrl.alu_src_b = riscv_pkg::src_ext_imm;
            end
            op_imm, op_reg: begin
                ctrl.reg_we = 1'b1;
                if (opcode == op_imm) begin
                    ctrl.alu_src_b = riscv_pkg::src_ext_imm;
                    // shifts take shamt instead of the i immediate.
                    if (funct3 == 3'b001 || funct3 == 3'b101) begin
                        ctrl.imm_src = riscv_pkg::imm_itype2;
                    end
                end
                case (funct3)
                    3'b000: begin
                        // sub exists only in register form.
                        if (opcode == op_reg && f7b5) begin
                            ctrl.alu_ctrl = riscv_pkg::alu_sub;
                        end
                    end
                    3'b001:  ctrl.alu_ctrl = riscv_pkg::alu_sll;
                    3'b010:  ctrl.alu_ctrl = riscv_pkg::alu_slt;
                    3'b100:  ctrl.alu_ctrl = riscv_pkg::alu_xor;
                    3'b110:  ctrl.alu_ctrl = riscv_pkg::alu_or;
                    3'b111:  ctrl.alu_ctrl = riscv_pkg::alu_and;
                    3'b101: begin
                        // arithmetic shift not supported.
                        ctrl.alu_ctrl = riscv_pkg::alu_srl;
                        ctrl.reg_we = !f7b5;
                    end
                    // unsigned compare not supported.
                    default: ctrl.reg_we = 1'b0;
                endcase
            end
            op_load: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_src_b = riscv_pkg::src_ext_imm;
                ctrl.result_src = riscv_pkg::res_mem;
            end
            op_store: begin
                ctrl.mem_we = 1'b1;
                ctrl.imm_src = riscv_pkg::imm_stype;
                ctrl.alu_src_b = riscv_pkg::src_ext_imm;
            end
            op_branch: begin
                // compare rs1 - rs2, target from the b immediate.
                ctrl.imm_src = riscv_pkg::imm_btype;
                ctrl.alu_ctrl = riscv_pkg::alu_sub;
                ctrl.pc_src = taken ? riscv_pkg::pc_plus_off : riscv_pkg::pc_plus_4;
            end
            op_jal: begin
                ctrl.reg_we = 1'b1;
                ctrl.imm_src = riscv_pkg::imm_jtype;
                ctrl.result_src = riscv_pkg::res_pc_plus_4;
                ctrl.pc_src = riscv_pkg::pc_plus_off;
            end
            op_jalr: begin
                ctrl.reg_we = 1'b1;
                ctrl.result_src = riscv_pkg::res_pc_plus_4;
                ctrl.pc_src = riscv_pkg::pc_reg_plus_off;
            end
            default: begin
                // unknown opcode, plain fall through.
            end
        endcase
        // no state changes while held in reset.
        if (!rst_n) begin
            ctrl.reg_we = 1'b0;
            ctrl.mem_we = 1'b0;
        end
    end

endmodule

// File: source/riscv_core.sv
module riscv_core #(
    parameter riscv_pkg::word_t reset_pc = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  riscv_pkg::word_t instr,
    input  riscv_pkg::word_t read_data,
    output riscv_pkg::word_t pc,
    output riscv_pkg::word_t data_addr,
    output riscv_pkg::word_t write_data,
    output logic             mem_we
);

    // decoder output and status back from the alu.
    riscv_pkg::ctrl_t      ctrl;
    riscv_pkg::alu_flags_t alu_flags;

    control_unit control_unit_inst (
        .rst_n     (rst_n),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    // alu output doubles as the data address.
    datapath #(
        .reset_pc (reset_pc)
    ) datapath_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_out    (data_addr),
        .alu_flags  (alu_flags),
        .write_data (write_data)
    );

    // store strobe goes straight to the memory port.
    assign mem_we = ctrl.mem_we;

endmodule

// File: sim/tb_riscv_core.sv
module tb_riscv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam riscv_pkg::word_t reset_pc = 32'h0000_0000;
    localparam int mem_words = 64;
    localparam int store_timeout = 2000;
    localparam int quiet_cycles = 20;
    localparam int straight_cycles = 8;
    // sw x0, 0(x0), fetched while held in reset.
    localparam riscv_pkg::word_t reset_store = 32'h0000_2023;

    logic             clk;
    logic             rst_n;
    riscv_pkg::word_t instr;
    riscv_pkg::word_t read_data;
    riscv_pkg::word_t pc;
    riscv_pkg::word_t data_addr;
    riscv_pkg::word_t write_data;
    logic             mem_we;

    // word-addressed program and data memories.
    riscv_pkg::word_t imem [mem_words];
    riscv_pkg::word_t dmem [mem_words];

    // expected stores, in program order.
    riscv_pkg::word_t exp_addr [$];
    riscv_pkg::word_t exp_data [$];
    int               store_idx;
    int               errors;

    riscv_core #(
        .reset_pc (reset_pc)
    ) riscv_core_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_we     (mem_we)
    );

    // 4 ns clock.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // both memories answer in the same cycle.
    // a store sits on the instruction bus while in reset, mem_we must stay low.
    assign instr = rst_n ? imem[pc[7:2]] : reset_store;
    assign read_data = dmem[data_addr[7:2]];

    // store lands on the edge that ends the sw.
    always @(posedge clk) begin
        if (rst_n && mem_we) begin
            dmem[data_addr[7:2]] <= write_data;
        end
    end

    task automatic check_equal(input riscv_pkg::word_t actual, input riscv_pkg::word_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // background patterns, unknown opcodes in the program space.
    task automatic fill_memories();
        riscv_pkg::word_t byte_addr;
        for (int i = 0; i < mem_words; i++) begin
            byte_addr = riscv_pkg::word_t'(i) << 2;
            imem[i] = byte_addr << 7;
            dmem[i] <= 32'ha5a5_0000 ^ byte_addr;
        end
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 code;
        logic [7:0]         kind;
        riscv_pkg::word_t   addr;
        riscv_pkg::word_t   word;
        logic [8*128-1:0]   rest;
        bit                 done;
        fd = $fopen("sim/riscv_core_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/riscv_core_vectors.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    // comment, drop the rest of the line.
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %h", addr, word);
                    if (code != 2) begin
                        $display("malformed vector line of kind %c", kind);
                        errors++;
                        done = 1'b1;
                    end else begin
                        case (kind)
                            "P": imem[addr[7:2]] = word;
                            "D": dmem[addr[7:2]] <= word;
                            "S": begin
                                exp_addr.push_back(addr);
                                exp_data.push_back(word);
                            end
                            default: begin
                                $display("unknown vector line kind %c", kind);
                                errors++;
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // every store strobe is matched against the next expected entry.
    always @(negedge clk) begin
        if (rst_n && mem_we) begin
            if (store_idx < exp_addr.size()) begin
                check_equal(data_addr, exp_addr[store_idx],
                            $sformatf("address of store %0d", store_idx));
                check_equal(write_data, exp_data[store_idx],
                            $sformatf("data of store %0d", store_idx));
                store_idx++;
            end else begin
                $display("unexpected store of %h to address %h after the last expected store",
                         write_data, data_addr);
                errors++;
            end
        end
    end

    initial begin
        int i;
        int cycles;
        rst_n = 1'b0;
        errors = 0;
        store_idx = 0;
        fill_memories();
        load_vectors();
        // ten edges in reset, pc parked and no stores.
        for (i = 0; i < 9; i++) begin
            @(negedge clk);
            check_equal({31'd0, mem_we}, 32'd0, "mem_we during reset");
            check_equal(pc, reset_pc, "pc during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        // program opens with straight-line code.
        for (i = 0; i < straight_cycles; i++) begin
            @(negedge clk);
            check_equal(pc, reset_pc + riscv_pkg::word_t'(4 * i), "pc after reset");
        end
        cycles = 0;
        while (store_idx < exp_addr.size() && cycles < store_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < exp_addr.size()) begin
            $display("timeout: %0d of %0d expected stores did not happen within %0d cycles",
                     exp_addr.size() - store_idx, exp_addr.size(), store_timeout);
            errors++;
        end
        // core now spins on its final jal, any store is extra.
        repeat (quiet_cycles) @(posedge clk);
        $display("stores checked: %0d of %0d, errors: %0d", store_idx, exp_addr.size(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim/riscv_core_vectors.txt
# kind address data (hex). P = program word, D = initial data word,
# S = expected store address and data, in program order. text after # is ignored.
P 00000000 08000093 # addi x1, x0, 128
P 00000004 00500113 # addi x2, x0, 5
P 00000008 ffd00193 # addi x3, x0, -3
P 0000000c 00310233 # add  x4, x2, x3
P 00000010 0040a023 # sw   x4, 0(x1)
P 00000014 40310233 # sub  x4, x2, x3
P 00000018 0040a223 # sw   x4, 4(x1)
P 0000001c 00317233 # and  x4, x2, x3
P 00000020 0040a423 # sw   x4, 8(x1)
P 00000024 00316233 # or   x4, x2, x3
P 00000028 0040a623 # sw   x4, 12(x1)
P 0000002c 00314233 # xor  x4, x2, x3
P 00000030 0040a823 # sw   x4, 16(x1)
P 00000034 0021a233 # slt  x4, x3, x2
P 00000038 0040aa23 # sw   x4, 20(x1)
P 0000003c 00211233 # sll  x4, x2, x2
P 00000040 0040ac23 # sw   x4, 24(x1)
P 00000044 0021d233 # srl  x4, x3, x2
P 00000048 0040ae23 # sw   x4, 28(x1)
P 0000004c ffe12213 # slti x4, x2, -2
P 00000050 0240a023 # sw   x4, 32(x1)
P 00000054 0f01f213 # andi x4, x3, 0xf0
P 00000058 0240a223 # sw   x4, 36(x1)
P 0000005c 70016213 # ori  x4, x2, 0x700
P 00000060 0240a423 # sw   x4, 40(x1)
P 00000064 fff14213 # xori x4, x2, -1
P 00000068 0240a623 # sw   x4, 44(x1)
P 0000006c 01c11213 # slli x4, x2, 28
P 00000070 0240a823 # sw   x4, 48(x1)
P 00000074 0041d213 # srli x4, x3, 4
P 00000078 0240aa23 # sw   x4, 52(x1)
P 0000007c 123452b7 # lui  x5, 0x12345
P 00000080 fe50ae23 # sw   x5, -4(x1)
P 00000084 00001317 # auipc x6, 1
P 00000088 fe60ac23 # sw   x6, -8(x1)
P 0000008c 0400a383 # lw   x7, 64(x1)
P 00000090 fe70aa23 # sw   x7, -12(x1)
P 00000094 0440a403 # lw   x8, 68(x1)
P 00000098 fe80a823 # sw   x8, -16(x1)
P 0000009c 00700013 # addi x0, x0, 7
P 000000a0 fe00a623 # sw   x0, -20(x1)
P 000000a4 00310463 # beq  x2, x3, 8 (not taken)
P 000000a8 00210463 # beq  x2, x2, 8 (taken)
P 000000ac fc30a823 # sw   x3, -48(x1) must be skipped
P 000000b0 00211463 # bne  x2, x2, 8 (not taken)
P 000000b4 00311463 # bne  x2, x3, 8 (taken)
P 000000b8 fc30a823 # sw   x3, -48(x1) must be skipped
P 000000bc 00314463 # blt  x2, x3, 8 (not taken)
P 000000c0 0021c463 # blt  x3, x2, 8 (taken)
P 000000c4 fc30a823 # sw   x3, -48(x1) must be skipped
P 000000c8 0021d463 # bge  x3, x2, 8 (not taken)
P 000000cc 00315463 # bge  x2, x3, 8 (taken)
P 000000d0 fc30a823 # sw   x3, -48(x1) must be skipped
P 000000d4 fe20a423 # sw   x2, -24(x1) marker after branches
P 000000d8 008004ef # jal  x9, 8
P 000000dc fc30a823 # sw   x3, -48(x1) must be skipped
P 000000e0 fe90a223 # sw   x9, -28(x1)
P 000000e4 01048567 # jalr x10, 16(x9)
P 000000e8 fc30a823 # sw   x3, -48(x1) must be skipped
P 000000ec fea0a023 # sw   x10, -32(x1)
P 000000f0 0000006f # jal  x0, 0
D 000000c0 cafef00d
D 000000c4 80000001
S 00000080 00000002 # add
S 00000084 00000008 # sub
S 00000088 00000005 # and
S 0000008c fffffffd # or
S 00000090 fffffff8 # xor
S 00000094 00000001 # slt, signed
S 00000098 000000a0 # sll
S 0000009c 07ffffff # srl
S 000000a0 00000000 # slti, signed
S 000000a4 000000f0 # andi
S 000000a8 00000705 # ori
S 000000ac fffffffa # xori
S 000000b0 50000000 # slli
S 000000b4 0fffffff # srli
S 0000007c 12345000 # lui
S 00000078 00001084 # auipc
S 00000074 cafef00d # lw, sw
S 00000070 80000001 # lw, sw
S 0000006c 00000000 # x0
S 00000068 00000005 # branch marker
S 00000064 000000dc # jal link
S 00000060 000000e8 # jalr link

// File: riscv_core.f
source/riscv_pkg.sv
source/extend.sv
source/regfile.sv
source/alu.sv
source/datapath.sv
source/control_unit.sv
source/riscv_core.sv
sim/tb_riscv_core.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - source/riscv_pkg.sv
  - source/extend.sv
  - source/regfile.sv
  - source/alu.sv
  - source/datapath.sv
  - source/control_unit.sv
  - source/riscv_core.sv
  - target: simulation
    files:
      - sim/tb_riscv_core.sv
